// File: common/cpu_pkg.sv
// shared types and fixed encodings for the integer core; floating-point opcodes are not defined
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes, instr[31:26]
  typedef enum logic [5:0] {
    op_rtype = 6'd0,
    op_addi  = 6'd1,
    op_andi  = 6'd2,
    op_ori   = 6'd3,
    op_xori  = 6'd4,
    op_addui = 6'd5,
    op_lw    = 6'd7,
    op_sw    = 6'd8,
    op_slti  = 6'd9,
    op_seq   = 6'd10,
    op_lui   = 6'd11,
    op_beq   = 6'd16,
    op_bne   = 6'd17,
    op_bgt   = 6'd18,
    op_bgte  = 6'd19,
    op_ble   = 6'd20,
    op_bleq  = 6'd21,
    op_bleu  = 6'd22,  // compares signed
    op_bgtu  = 6'd23,  // likewise signed
    op_j_a   = 6'd24,
    op_j_b   = 6'd25,  // jr-style jump with the same target handling
    op_jal   = 6'd26
  } opcode_e;

  // R-type function codes, instr[5:0]
  typedef enum logic [5:0] {
    fn_add    = 6'd0,
    fn_sub    = 6'd1,
    fn_and    = 6'd2,
    fn_or     = 6'd3,
    fn_not    = 6'd4,
    fn_xor    = 6'd5,
    fn_addu   = 6'd6,  // same datapath as add
    fn_subu   = 6'd7,  // same datapath as sub
    fn_slt    = 6'd8,
    fn_sll    = 6'd9,
    fn_srl    = 6'd10,
    fn_mul_hi = 6'd11,
    fn_mul_lo = 6'd12
  } funct_e;

  // ALU operation select
  typedef enum logic [4:0] {
    alu_add    = 5'd0,
    alu_sub    = 5'd1,   // a - b
    alu_and    = 5'd2,
    alu_xor    = 5'd3,
    alu_or     = 5'd4,
    alu_not    = 5'd5,   // ~a
    alu_sll    = 5'd6,
    alu_srl    = 5'd7,
    alu_sne    = 5'd8,
    alu_seq    = 5'd9,
    alu_slt    = 5'd10,
    alu_sle    = 5'd11,
    alu_sgt    = 5'd12,
    alu_sge    = 5'd13,
    alu_lui    = 5'd14,  // b << 16
    alu_mul_lo = 5'd15,
    alu_mul_hi = 5'd16,
    alu_bad    = 5'd31
  } alu_op_e;

  // marker for undefined operations
  localparam word_t BAD_RESULT = 32'hdeadbeef;

  // jal link register
  localparam reg_idx_t RA_INDEX = 5'd3;

endpackage

// File: src/word_memory.sv
// 2**addr_width words, combinational read, write on rising clk; contents not reset
module word_memory #(
  parameter int addr_width = 10
) (
  input  logic                  clk,
  input  logic                  we,
  input  logic [addr_width-1:0] waddr,
  input  cpu_pkg::word_t        wdata,
  input  logic [addr_width-1:0] raddr,
  output cpu_pkg::word_t        rdata
);
  import cpu_pkg::*;

  localparam int depth = 2 ** addr_width;

  word_t mem [depth];

  assign rdata = mem[raddr];  // read during the same cycle

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

endmodule

// File: core/decoder.sv
// field split plus control decode; controls forced low while rst, unknown codes give alu_bad
module decoder (
  input  logic              rst,
  input  cpu_pkg::word_t    instr,
  output cpu_pkg::reg_idx_t rd,
  output cpu_pkg::reg_idx_t rt,
  output cpu_pkg::reg_idx_t rs,
  output logic [4:0]        shamt,
  output logic [15:0]       imm,
  output logic [25:0]       jtarget,
  output logic              reg_write,
  output logic              mem_write,
  output logic              immediate,
  output logic              mem_to_reg,
  output logic              branch,
  output logic              jump,
  output logic              jal,
  output cpu_pkg::alu_op_e  alu_op
);
  import cpu_pkg::*;

  opcode_e opcode;
  funct_e  funct;

  // instruction fields
  assign opcode  = opcode_e'(instr[31:26]);
  assign rd      = instr[25:21];
  assign rt      = instr[20:16];
  assign rs      = instr[15:11];
  assign shamt   = instr[10:6];
  assign funct   = funct_e'(instr[5:0]);
  assign imm     = instr[15:0];
  assign jtarget = instr[25:0];

  // main control
  always_comb begin
    reg_write  = 1'b0;
    mem_write  = 1'b0;
    immediate  = 1'b0;
    mem_to_reg = 1'b0;
    branch     = 1'b0;
    jump       = 1'b0;
    jal        = 1'b0;
    if (!rst) begin
      case (opcode)
        op_rtype: reg_write = 1'b1;
        op_addi, op_andi, op_ori, op_xori, op_addui, op_slti, op_seq, op_lui: begin
          reg_write = 1'b1;
          immediate = 1'b1;
        end
        op_lw: begin
          reg_write  = 1'b1;
          immediate  = 1'b1;
          mem_to_reg = 1'b1;
        end
        op_sw: begin
          mem_write = 1'b1;
          immediate = 1'b1;
        end
        op_beq, op_bne, op_bgt, op_bgte, op_ble, op_bleq, op_bleu, op_bgtu: branch = 1'b1;
        op_j_a, op_j_b: jump = 1'b1;
        op_jal: begin
          reg_write = 1'b1;
          jump      = 1'b1;
          jal       = 1'b1;
        end
        default: ;  // unknown opcode acts as a nop
      endcase
    end
  end

  // ALU control
  always_comb begin
    case (opcode)
      op_lw, op_sw, op_addi, op_addui: alu_op = alu_add;  // address or sum
      op_andi:                        alu_op = alu_and;
      op_ori:                         alu_op = alu_or;
      op_xori:                        alu_op = alu_xor;
      op_slti, op_ble, op_bleu:       alu_op = alu_slt;
      op_seq, op_beq:                 alu_op = alu_seq;
      op_bne:                         alu_op = alu_sne;
      op_bgt, op_bgtu:                alu_op = alu_sgt;
      op_bgte:                        alu_op = alu_sge;
      op_bleq:                        alu_op = alu_sle;
      op_lui:                         alu_op = alu_lui;
      op_rtype: begin
        case (funct)
          fn_add, fn_addu: alu_op = alu_add;
          fn_sub, fn_subu: alu_op = alu_sub;
          fn_and:          alu_op = alu_and;
          fn_or:           alu_op = alu_or;
          fn_not:          alu_op = alu_not;
          fn_xor:          alu_op = alu_xor;
          fn_slt:          alu_op = alu_slt;
          fn_sll:          alu_op = alu_sll;
          fn_srl:          alu_op = alu_srl;
          fn_mul_hi:       alu_op = alu_mul_hi;
          fn_mul_lo:       alu_op = alu_mul_lo;
          default:         alu_op = alu_bad;
        endcase
      end
      default: alu_op = alu_bad;  // jumps land here too
    endcase
  end

endmodule

// File: core/alu.sv
// compares are signed and return 0 or 1; undefined ops return BAD_RESULT
module alu (
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::alu_op_e op,
  input  logic [4:0]       shamt,
  output cpu_pkg::word_t   result
);
  import cpu_pkg::*;

  logic signed [63:0] product;
  logic               lt;
  logic               eq;

  assign product = $signed(a) * $signed(b);  // full signed product
  assign lt      = $signed(a) < $signed(b);
  assign eq      = a == b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_xor:    result = a ^ b;
      alu_or:     result = a | b;
      alu_not:    result = ~a;
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;  // logical
      alu_sne:    result = {31'b0, !eq};
      alu_seq:    result = {31'b0, eq};
      alu_slt:    result = {31'b0, lt};
      alu_sle:    result = {31'b0, lt | eq};
      alu_sgt:    result = {31'b0, !(lt | eq)};
      alu_sge:    result = {31'b0, !lt};
      alu_lui:    result = b << 16;
      alu_mul_lo: result = product[31:0];
      alu_mul_hi: result = product[63:32];
      default:    result = BAD_RESULT;
    endcase
  end

endmodule

// File: core/reg_file.sv
// 32 general registers, two combinational reads, sync clear on rst; r0 is writable
module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  cpu_pkg::reg_idx_t waddr,
  input  cpu_pkg::word_t    wdata,
  input  cpu_pkg::reg_idx_t rt_idx,
  output cpu_pkg::word_t    rt_data,
  input  cpu_pkg::reg_idx_t rs_idx,
  output cpu_pkg::word_t    rs_data
);
  import cpu_pkg::*;

  word_t regs [32];

  // read ports see the old value until the edge
  assign rt_data = regs[rt_idx];
  assign rs_data = regs[rs_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// File: core/pc_unit.sv
// needs addr_width <= 26; past pc_limit the pc holds unless a jump or branch moves it
module pc_unit #(
  parameter int addr_width = 10,
  parameter int pc_limit   = 100
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  jump,
  input  logic [25:0]           jtarget,
  input  logic                  branch_taken,
  input  logic [15:0]           offset,
  output logic [addr_width-1:0] pc
);

  localparam logic [addr_width-1:0] limit = addr_width'(pc_limit);
  localparam logic [addr_width-1:0] one   = addr_width'(1);

  logic [31:0] offset_sx;

  assign offset_sx = {{16{offset[15]}}, offset};  // signed branch offset

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (jump) begin
      pc <= jtarget[addr_width-1:0];
    end else if (branch_taken) begin
      pc <= pc + one + offset_sx[addr_width-1:0];
    end else if (pc <= limit) begin
      pc <= pc + one;
    end
  end

endmodule

// File: src/cpu_top.sv
// single-cycle core, one instruction per clk; load strobes write memories even during rst
module cpu_top #(
  parameter int addr_width = 10,
  parameter int pc_limit   = 100
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [addr_width-1:0] load_addr,
  input  cpu_pkg::word_t        load_word,
  input  logic                  load_instr,
  input  logic                  load_data,
  output cpu_pkg::word_t        rs_value,
  output logic [addr_width-1:0] pc
);
  import cpu_pkg::*;

  word_t    instr;
  reg_idx_t rd, rt, rs;
  logic [4:0]  shamt;
  logic [15:0] imm;
  logic [25:0] jtarget;
  logic     reg_write, mem_write, immediate, mem_to_reg, branch, jump, jal;
  alu_op_e  alu_op;

  word_t    rt_value;
  reg_idx_t rs_idx;
  word_t    imm_ext;
  word_t    alu_b;
  word_t    alu_result;
  word_t    mem_word;
  logic [addr_width-1:0] dmem_waddr;
  word_t    dmem_wdata;
  word_t    wb_data;
  reg_idx_t wb_idx;
  logic     branch_taken;

  assign imm_ext = {{16{imm[15]}}, imm};
  assign rs_idx  = (branch | mem_write) ? rd : rs;  // branches and stores read rd
  assign alu_b   = immediate ? imm_ext : rs_value;

  // external load shares the data memory write port
  assign dmem_waddr = load_data ? load_addr : alu_result[addr_width-1:0];
  assign dmem_wdata = load_data ? load_word : rs_value;

  // jal links pc+1 into r3 instead of the normal write-back
  assign wb_data = jal ? word_t'(pc) + 32'd1 : (mem_to_reg ? mem_word : alu_result);
  assign wb_idx  = jal ? RA_INDEX : rd;

  assign branch_taken = branch & alu_result[0];

  word_memory #(.addr_width(addr_width)) u_imem (
    .clk   (clk),
    .we    (load_instr),
    .waddr (load_addr),
    .wdata (load_word),
    .raddr (pc),
    .rdata (instr)
  );

  word_memory #(.addr_width(addr_width)) u_dmem (
    .clk   (clk),
    .we    (load_data | mem_write),
    .waddr (dmem_waddr),
    .wdata (dmem_wdata),
    .raddr (alu_result[addr_width-1:0]),
    .rdata (mem_word)
  );

  decoder u_decoder (
    .rst        (rst),
    .instr      (instr),
    .rd         (rd),
    .rt         (rt),
    .rs         (rs),
    .shamt      (shamt),
    .imm        (imm),
    .jtarget    (jtarget),
    .reg_write  (reg_write),
    .mem_write  (mem_write),
    .immediate  (immediate),
    .mem_to_reg (mem_to_reg),
    .branch     (branch),
    .jump       (jump),
    .jal        (jal),
    .alu_op     (alu_op)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .we      (reg_write),
    .waddr   (wb_idx),
    .wdata   (wb_data),
    .rt_idx  (rt),
    .rt_data (rt_value),
    .rs_idx  (rs_idx),
    .rs_data (rs_value)
  );

  alu u_alu (
    .a      (rt_value),
    .b      (alu_b),
    .op     (alu_op),
    .shamt  (shamt),
    .result (alu_result)
  );

  pc_unit #(.addr_width(addr_width), .pc_limit(pc_limit)) u_pc_unit (
    .clk          (clk),
    .rst          (rst),
    .jump         (jump),
    .jtarget      (jtarget),
    .branch_taken (branch_taken),
    .offset       (imm),
    .pc           (pc)
  );

endmodule

// File: sim/tb_clock.sv
// 100 ns clock starting low; rst high for the first 3 cycles and for as long as hold stays high
module tb_clock (
  input  logic hold,
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk_q   = 1'b0;
  logic        rst_q   = 1'b1;
  int unsigned n_edges = 0;

  assign clk = clk_q;
  assign rst = rst_q;

  always #50 clk_q = ~clk_q;

  // updates land after the edge, so the DUT samples the old level
  always @(posedge clk_q) begin
    if (n_edges < 3) begin
      n_edges <= n_edges + 1;
    end
    rst_q <= (n_edges < 2) || hold;
  end

endmodule

// File: sim/cpu_tb.sv
// runs from the project root; reads sim/program_stimulus.txt, expects addr_width 10, pc_limit 100
module cpu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int    addr_width    = 10;
  localparam int    pc_limit      = 100;
  localparam int    reset_timeout = 2000;  // cycles
  localparam string stim_path     = "sim/program_stimulus.txt";

  logic                  clk;
  logic                  rst;
  logic                  hold_reset;
  logic [addr_width-1:0] load_addr;
  word_t                 load_word;
  logic                  load_instr;
  logic                  load_data;
  word_t                 rs_value;
  logic [addr_width-1:0] pc;

  // load records in file order
  byte         load_kind_q [$];
  logic [31:0] load_addr_q [$];
  word_t       load_word_q [$];

  // expected results for each cycle after reset
  logic [31:0] exp_pc_q [$];
  word_t       exp_rs_q [$];

  tb_clock u_clock (
    .hold (hold_reset),
    .clk  (clk),
    .rst  (rst)
  );

  cpu_top #(.addr_width(addr_width), .pc_limit(pc_limit)) u_dut (
    .clk        (clk),
    .rst        (rst),
    .load_addr  (load_addr),
    .load_word  (load_word),
    .load_instr (load_instr),
    .load_data  (load_data),
    .rs_value   (rs_value),
    .pc         (pc)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_pc(input logic [addr_width-1:0] got, input logic [addr_width-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH pc: got %h expected %h", got, exp);
      fail_run("pc differs from the expected value");
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      fail_run("data word differs from the expected value");
    end
  endtask

  task automatic read_stimulus();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] f0;
    logic [31:0] f1;
    fd = $fopen(stim_path, "r");
    if (fd == 0) begin
      fail_run("could not open the stimulus file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin  // skip comments and blank lines
          kind = line[0];
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h", f0, f1);
          if (n != 2) begin
            fail_run("malformed record in the stimulus file");
          end else if (kind == "I" || kind == "D") begin
            load_kind_q.push_back(kind);
            load_addr_q.push_back(f0);
            load_word_q.push_back(f1);
          end else if (kind == "E") begin
            exp_pc_q.push_back(f0);
            exp_rs_q.push_back(f1);
          end else begin
            fail_run("unknown record kind in the stimulus file");
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int waited;
    hold_reset = 1'b1;
    load_addr  = '0;
    load_word  = '0;
    load_instr = 1'b0;
    load_data  = 1'b0;
    read_stimulus();

    // one load per cycle while reset is held
    for (int i = 0; i < load_kind_q.size(); i++) begin
      @(posedge clk);
      #1;
      load_addr  = load_addr_q[i][addr_width-1:0];
      load_word  = load_word_q[i];
      load_instr = (load_kind_q[i] == "I");
      load_data  = (load_kind_q[i] == "D");
    end
    @(posedge clk);
    #1;
    load_instr = 1'b0;
    load_data  = 1'b0;
    hold_reset = 1'b0;

    waited = 0;
    while (rst === 1'b1 && waited < reset_timeout) begin
      @(posedge clk);
      #1;
      waited++;
    end

    if (rst !== 1'b0) begin
      fail_run("timeout waiting for reset release");
    end else begin
      // sample mid-cycle once outputs settle
      for (int i = 0; i < exp_pc_q.size(); i++) begin
        @(negedge clk);
        check_pc(pc, exp_pc_q[i][addr_width-1:0]);
        check_word("rs_value", rs_value, exp_rs_q[i]);
      end
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: sources.f
common/cpu_pkg.sv
src/word_memory.sv
core/decoder.sv
core/alu.sv
core/reg_file.sv
core/pc_unit.sv
src/cpu_top.sv
sim/tb_clock.sv
sim/cpu_tb.sv

// File: Makefile
# Verilator flow for the single-cycle core; run from the project root
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
SIM_BIN   ?= V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/program_stimulus.txt
# I addr word = instruction load, D addr word = data load (hex)
# E pc rs_value = expected outputs for each cycle after reset (hex)
I 000 04200005
I 001 0440FFFD
I 002 00811000
I 003 00A11001
I 004 00C11002
I 005 00E11003
I 006 01011005
I 007 01212004
I 008 01412909
I 009 0162370A
I 00A 01820808
I 00B 01A2080C
I 00C 01C2080B
I 00D 2DE01234
I 00E 18004000
I 00F 18004800
I 010 18005000
I 011 18005800
I 012 18006000
I 013 18006800
I 014 18007000
I 015 18007800
I 016 18003800
I 017 0A010006
I 018 0E21000A
I 019 1241000F
I 01A 26620000
I 01B 2A810005
I 01C 16A10010
I 01D 02D08800
I 01E 18008000
I 01F 18009000
I 020 18009800
I 021 1800A000
I 022 1800A800
I 023 1800B000
I 024 20A10010
I 025 1EE10010
I 026 1F000020
I 027 1800B800
I 028 1800C000
I 029 40210002
I 02C 44210005
I 02D 48410001
I 02F 50410003
I 030 54220001
I 032 4C220004
I 033 6800003C
I 03C 18001800
I 03D 60000062
I 062 18001800
I 063 18000800
I 064 18002000
I 065 18000000
D 020 CAFEF00D
# arithmetic and logic
E 000 00000000
E 001 00000000
E 002 FFFFFFFD
E 003 FFFFFFFD
E 004 FFFFFFFD
E 005 FFFFFFFD
E 006 FFFFFFFD
E 007 00000002
E 008 00000008
E 009 00000005
E 00A 00000005
E 00B 00000005
E 00C 00000005
E 00D FFFFFFFD
E 00E FFFFFFF8
E 00F FFFFFFFA
E 010 00000050
E 011 0000000F
E 012 00000001
E 013 FFFFFFF1
E 014 FFFFFFFF
E 015 12340000
E 016 FFFFFFFD
# immediates
E 017 00000000
E 018 00000000
E 019 00000000
E 01A 00000000
E 01B 00000000
E 01C 00000000
E 01D 0000000F
E 01E 00000004
E 01F 0000000A
E 020 00000001
E 021 00000001
E 022 00000015
E 023 00000013
# store and loads
E 024 00000008
E 025 00000000
E 026 00000000
E 027 00000008
E 028 CAFEF00D
# branches
E 029 00000005
E 02C 00000005
E 02D FFFFFFFD
E 02F FFFFFFFD
E 030 00000005
E 032 00000005
# jal, j, then the pc limit
E 033 00000000
E 03C 00000034
E 03D 00000000
E 062 00000034
E 063 00000005
E 064 00000002
E 065 00000000
E 065 00000000
E 065 00000000
